/* flist.f */
common/calc_pkg.sv
common/lane_bus_if.sv
hdl/word_ram.sv
calc_decode/calc_decode.sv
lane_mul_add/lane_mul_add.sv
hdl/result_writeback.sv
hdl/calc_top.sv
verification/calc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module calc_tb \
    -Mdir obj_dir -o calc_sim > build.log 2>&1 \
    && ./obj_dir/calc_sim > sim.log 2>&1 \
    && ! grep -q "TEST FAIL" sim.log \
    && grep -q "TEST PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* verification/calc_tb.sv */
`timescale 1ns/10ps

module calc_tb import calc_pkg::*; ();

    localparam int WORDS      = 2**ADDR_BITS;
    localparam int POLL_LIMIT = 100;
    // six sweeps of both banks plus register and status traffic.
    localparam int APB_XFERS       = 6 * 4 * WORDS + 300;
    localparam int WATCHDOG_CYCLES = APB_XFERS * 4 + 500;

    typedef struct packed {
        word_t prod;
        word_t sum;
    } lane_pair_t;

    logic      clk;
    logic      reset;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      done;

    logic [31:0] lfsr_state;
    word_t       src0_m [WORDS];
    word_t       src1_m [WORDS];
    word_t       prod_m [WORDS];   // expected destination banks.
    word_t       sum_m  [WORDS];
    int          error_count;
    int          check_count;
    int          test_errors;
    int          test_count;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    calc_top u_dut (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .done    (done)
    );

    ////////////////////
    // reference model
    ////////////////////
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic random_half(output apb_data_t v);
        v = '0;
        for (int i = 0; i < HALF_BITS; i++) begin
            v = {v[HALF_BITS-2:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic lane_pair_t lane_ref(word_t a, word_t b);
        lane_pair_t r;
        int x;
        int y;
        int p;
        int s;
        for (int l = 0; l < LANES; l++) begin
            x = int'($signed(a[l*DATA_BITS +: DATA_BITS]));
            y = int'($signed(b[l*DATA_BITS +: DATA_BITS]));
            p = x * y;
            s = x + y;
            r.prod[l*DATA_BITS +: DATA_BITS] = p[DATA_BITS-1:0];   // low byte.
            r.sum[l*DATA_BITS +: DATA_BITS]  = s[DATA_BITS-1:0];
        end
        return r;
    endfunction

    task automatic model_run(input int sbase, input int dbase, input int len);
        lane_pair_t r;
        int s;
        int d;
        for (int k = 0; k < len; k++) begin
            s = (sbase + k) % WORDS;
            d = (dbase + k) % WORDS;
            r = lane_ref(src0_m[s], src1_m[s]);
            prod_m[d] = r.prod;
            sum_m[d]  = r.sum;
        end
    endtask

    ////////////////////
    // compare tasks
    ////////////////////
    task automatic check_word(input string name, input word_t exp, input word_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input apb_data_t exp, input apb_data_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_waits(input string name, input int exp, input int act);
        check_count++;
        if (act != exp) begin
            error_count++;
            $display("[ERROR] %0t %s expected %0d wait states actual %0d",
                     $time, name, exp, act);
        end
    endtask

    ////////////////////
    // APB tasks
    ////////////////////
    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        int waits;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b1;
        pwdata  <= data;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        waits = 0;
        while (!pready) begin
            waits++;
            @(posedge clk);
        end
        check_waits("pready", 0, waits);    // writes never stall.
        err = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // a negative exp_waits leaves the stall length unchecked.
    task automatic apb_read(input apb_addr_t addr, input int exp_waits,
                            output apb_data_t data, output logic err);
        int waits;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        waits = 0;
        while (!pready) begin
            waits++;
            @(posedge clk);     // window reads wait one cycle.
        end
        data = prdata;
        err  = pslverr;
        if (exp_waits >= 0) begin
            check_waits("pready", exp_waits, waits);
        end
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input string name, input apb_addr_t addr, input apb_data_t data);
        logic err;
        apb_write(addr, data, err);
        check_err({name, " pslverr"}, 1'b0, err);
    endtask

    task automatic expect_reg(input string name, input apb_addr_t addr, input apb_data_t exp);
        apb_data_t v;
        logic      err;
        apb_read(addr, 0, v, err);
        check_err({name, " pslverr"}, 1'b0, err);
        check_reg(name, exp, v);
    endtask

    task automatic access_error(input string name, input apb_addr_t addr, input logic wr,
                                input apb_data_t data);
        apb_data_t v;
        logic      err;
        if (wr) begin
            apb_write(addr, data, err);
        end else begin
            apb_read(addr, -1, v, err);
        end
        check_err({name, " pslverr"}, 1'b1, err);
    endtask

    function automatic apb_addr_t word_addr(apb_addr_t win, int idx, int half);
        return apb_addr_t'(int'(win) + idx * 8 + half * 4);
    endfunction

    task automatic fetch_word(input apb_addr_t win, input int idx, output word_t w);
        apb_data_t lo;
        apb_data_t hi;
        logic      err;
        apb_read(word_addr(win, idx, 0), 1, lo, err);
        check_err("window read pslverr", 1'b0, err);
        apb_read(word_addr(win, idx, 1), 1, hi, err);
        check_err("window read pslverr", 1'b0, err);
        w = {hi, lo};
    endtask

    task automatic fill_sources();
        apb_data_t lo;
        apb_data_t hi;
        for (int i = 0; i < WORDS; i++) begin
            random_half(lo);
            random_half(hi);
            src0_m[i] = {hi, lo};
            random_half(lo);
            random_half(hi);
            src1_m[i] = {hi, lo};
            write_reg("src0 window", word_addr(SRC0_WIN, i, 0), src0_m[i][HALF_BITS-1:0]);
            write_reg("src0 window", word_addr(SRC0_WIN, i, 1), src0_m[i][2*HALF_BITS-1:HALF_BITS]);
            write_reg("src1 window", word_addr(SRC1_WIN, i, 0), src1_m[i][HALF_BITS-1:0]);
            write_reg("src1 window", word_addr(SRC1_WIN, i, 1), src1_m[i][2*HALF_BITS-1:HALF_BITS]);
        end
    endtask

    task automatic start_run(input int sbase, input int dbase, input int len);
        write_reg("len", REG_LEN, apb_data_t'(len));
        write_reg("src_base", REG_SRC_BASE, apb_data_t'(sbase));
        write_reg("dst_base", REG_DST_BASE, apb_data_t'(dbase));
        write_reg("ctrl", REG_CTRL, 32'h1);
        model_run(sbase, dbase, len);
    endtask

    task automatic wait_done();
        apb_data_t v;
        logic      err;
        int        polls;
        v     = '0;
        polls = 0;
        while (!v[1] && polls < POLL_LIMIT) begin
            apb_read(REG_STATUS, 0, v, err);
            polls++;
        end
        if (!v[1]) begin
            error_count++;
            $display("run still not done after %0d status polls", polls);
        end else begin
            check_reg("status", 32'h2, v);      // busy falls with done.
            check_reg("done port", 32'h1, apb_data_t'(done));
        end
    endtask

    task automatic compare_results();
        word_t w;
        for (int i = 0; i < WORDS; i++) begin
            fetch_word(PROD_WIN, i, w);
            check_word($sformatf("prod[%0d]", i), prod_m[i], w);
            fetch_word(SUM_WIN, i, w);
            check_word($sformatf("sum[%0d]", i), sum_m[i], w);
        end
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (error_count == test_errors) begin
            $display("test %0d %s: passed", test_count, name);
        end else begin
            $display("test %0d %s: failed, %0d errors", test_count, name,
                     error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    ////////////////////
    // tests
    ////////////////////
    initial begin
        word_t w;
        lfsr_state  = 32'h0a3286f1;
        error_count = 0;
        check_count = 0;
        test_errors = 0;
        test_count  = 0;
        reset   = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        check_reg("done port", 32'h0, apb_data_t'(done));
        expect_reg("ctrl", REG_CTRL, 32'h0);
        expect_reg("status", REG_STATUS, 32'h0);
        expect_reg("len", REG_LEN, 32'h0);
        expect_reg("src_base", REG_SRC_BASE, 32'h0);
        expect_reg("dst_base", REG_DST_BASE, 32'h0);
        write_reg("len", REG_LEN, 32'd5);
        write_reg("src_base", REG_SRC_BASE, 32'd3);
        write_reg("dst_base", REG_DST_BASE, 32'd7);
        expect_reg("len", REG_LEN, 32'd5);
        expect_reg("src_base", REG_SRC_BASE, 32'd3);
        expect_reg("dst_base", REG_DST_BASE, 32'd7);
        write_reg("ctrl", REG_CTRL, 32'h2);
        expect_reg("ctrl", REG_CTRL, 32'h2);
        write_reg("len", REG_LEN, 32'd0);   // empty run, nothing written.
        write_reg("ctrl", REG_CTRL, 32'h1);
        expect_reg("ctrl", REG_CTRL, 32'h0);
        wait_done();
        finish_test("register access");

        fill_sources();
        start_run(0, 0, 64);
        wait_done();
        compare_results();
        finish_test("full run");

        start_run(50, 40, 30);
        wait_done();
        compare_results();
        finish_test("wrapped run");

        start_run(10, 20, 40);
        write_reg("ctrl", REG_CTRL, 32'h2);
        repeat (3) begin
            repeat (20) @(posedge clk);
            expect_reg("status", REG_STATUS, 32'h1);
            check_reg("done port", 32'h0, apb_data_t'(done));
        end
        write_reg("ctrl", REG_CTRL, 32'h0);
        wait_done();
        compare_results();
        finish_test("pause");

        access_error("unmapped write", 12'h014, 1'b1, 32'h3f);
        access_error("unmapped read", 12'h100, 1'b0, 32'h0);
        expect_reg("dst_base", REG_DST_BASE, 32'd20);
        access_error("prod window write", word_addr(PROD_WIN, 3, 0), 1'b1, 32'hdeadbeef);
        access_error("sum window write", word_addr(SUM_WIN, 3, 1), 1'b1, 32'h01234567);
        fetch_word(PROD_WIN, 3, w);
        check_word("prod[3]", prod_m[3], w);
        fetch_word(SUM_WIN, 3, w);
        check_word("sum[3]", sum_m[3], w);
        start_run(0, 0, 64);
        access_error("src0 write while busy", word_addr(SRC0_WIN, 5, 0), 1'b1,
                     ~src0_m[5][HALF_BITS-1:0]);
        access_error("src1 read while busy", word_addr(SRC1_WIN, 5, 1), 1'b0, 32'h0);
        wait_done();
        fetch_word(SRC0_WIN, 5, w);
        check_word("src0[5]", src0_m[5], w);
        compare_results();
        start_run(7, 9, 0);
        wait_done();
        compare_results();
        finish_test("error responses");

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // hard stop on a hung transfer or run.
    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("watchdog expired after %0d cycles, simulation stopped", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* hdl/calc_top.sv */
`timescale 1ns/10ps

module calc_top import calc_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    output logic      done
);

    logic       cke;
    logic       src_rd_en;
    addr_t      src_rd_addr;
    logic [1:0] src_wr_en;
    logic       src_wr_sel;
    addr_t      src_wr_addr;
    word_t      src_wr_data;
    addr_t      res_rd_addr;
    word_t      prod_rd_data;
    word_t      sum_rd_data;
    addr_t      dst_base;
    logic       run_done;
    logic       prod_we;
    logic       sum_we;
    addr_t      wr_addr;
    word_t      prod_data;
    word_t      sum_data;

    lane_bus_if issue ();
    lane_bus_if result ();

    calc_decode u_decode (
        .clk          (clk),
        .reset        (reset),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .done         (done),
        .cke          (cke),
        .src_rd_en    (src_rd_en),
        .src_rd_addr  (src_rd_addr),
        .src_wr_en    (src_wr_en),
        .src_wr_sel   (src_wr_sel),
        .src_wr_addr  (src_wr_addr),
        .src_wr_data  (src_wr_data),
        .res_rd_addr  (res_rd_addr),
        .prod_rd_data (prod_rd_data),
        .sum_rd_data  (sum_rd_data),
        .src0_rd_data (issue.data0),
        .src1_rd_data (issue.data1),
        .dst_base     (dst_base),
        .run_done     (run_done),
        .issue        (issue)
    );

    ////////////////////
    // source banks
    ////////////////////
    word_ram u_src0 (
        .clk     (clk),
        .wr_en   (src_wr_sel ? 2'b00 : src_wr_en),
        .wr_addr (src_wr_addr),
        .wr_data (src_wr_data),
        .rd_en   (src_rd_en),
        .rd_addr (src_rd_addr),
        .rd_data (issue.data0)
    );

    word_ram u_src1 (
        .clk     (clk),
        .wr_en   (src_wr_sel ? src_wr_en : 2'b00),
        .wr_addr (src_wr_addr),
        .wr_data (src_wr_data),
        .rd_en   (src_rd_en),
        .rd_addr (src_rd_addr),
        .rd_data (issue.data1)
    );

    lane_mul_add u_lanes (
        .clk    (clk),
        .reset  (reset),
        .cke    (cke),
        .issue  (issue),
        .result (result)
    );

    result_writeback u_writeback (
        .clk       (clk),
        .reset     (reset),
        .cke       (cke),
        .result    (result),
        .dst_base  (dst_base),
        .prod_we   (prod_we),
        .sum_we    (sum_we),
        .wr_addr   (wr_addr),
        .prod_data (prod_data),
        .sum_data  (sum_data),
        .run_done  (run_done)
    );

    ////////////////////
    // result banks
    ////////////////////
    word_ram u_prod (
        .clk     (clk),
        .wr_en   ({2{prod_we}}),
        .wr_addr (wr_addr),
        .wr_data (prod_data),
        .rd_en   (1'b1),
        .rd_addr (res_rd_addr),
        .rd_data (prod_rd_data)
    );

    word_ram u_sum (
        .clk     (clk),
        .wr_en   ({2{sum_we}}),
        .wr_addr (wr_addr),
        .wr_data (sum_data),
        .rd_en   (1'b1),
        .rd_addr (res_rd_addr),
        .rd_data (sum_rd_data)
    );

endmodule

/* hdl/result_writeback.sv */
`timescale 1ns/10ps

module result_writeback import calc_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    cke,
    lane_bus_if.dst result,
    input  addr_t   dst_base,
    output logic    prod_we,
    output logic    sum_we,
    output addr_t   wr_addr,
    output word_t   prod_data,
    output word_t   sum_data,
    output logic    run_done
);

    logic  active;  // between first and last word.
    addr_t ptr;

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            ptr    <= '0;
        end else if (cke) begin
            if (result.valid) begin
                active <= ~result.last;
                ptr    <= ptr + addr_t'(1);     // wraps at 64.
            end else if (!active) begin
                ptr <= dst_base;
            end
        end
    end

    assign prod_we   = cke & result.valid;
    assign sum_we    = cke & result.valid;
    assign wr_addr   = ptr;
    assign prod_data = result.data0;
    assign sum_data  = result.data1;
    assign run_done  = cke & result.valid & result.last;

    // nothing follows the final word of a run.
    a_last_closes_run: assert property (@(posedge clk) disable iff (reset)
        run_done |=> !result.valid);

endmodule

/* lane_mul_add/lane_mul_add.sv */
`timescale 1ns/10ps

module lane_mul_add import calc_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    cke,
    lane_bus_if.dst issue,
    lane_bus_if.src result
);

    word_t st0_data0;
    word_t st0_data1;
    logic  st0_valid;
    logic  st0_last;
    word_t lane_prod;
    word_t lane_sum;
    word_t st1_prod;
    word_t st1_sum;
    logic  st1_valid;
    logic  st1_last;
    word_t st2_prod;
    word_t st2_sum;
    logic  st2_valid;
    logic  st2_last;

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        lane_t a;
        lane_t b;
        assign a = st0_data0[i*DATA_BITS +: DATA_BITS];
        assign b = st0_data1[i*DATA_BITS +: DATA_BITS];
        assign lane_prod[i*DATA_BITS +: DATA_BITS] = a * b;   // low byte only.
        assign lane_sum[i*DATA_BITS +: DATA_BITS]  = a + b;   // wraps.
    end

    ////////////////////
    // stage valids
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            st0_valid <= 1'b0;
            st1_valid <= 1'b0;
            st2_valid <= 1'b0;
        end else if (cke) begin
            st0_valid <= issue.valid;
            st1_valid <= st0_valid;
            st2_valid <= st1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            st0_data0 <= issue.data0;
            st0_data1 <= issue.data1;
            st0_last  <= issue.last;
            st1_prod  <= lane_prod;
            st1_sum   <= lane_sum;
            st1_last  <= st0_last;
            st2_prod  <= st1_prod;
            st2_sum   <= st1_sum;
            st2_last  <= st1_last;
        end
    end

    assign result.data0 = st2_prod;
    assign result.data1 = st2_sum;
    assign result.valid = st2_valid;
    assign result.last  = st2_last;

    a_valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(result.valid));

endmodule

/* calc_decode/calc_decode.sv */
`timescale 1ns/10ps

module calc_decode import calc_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  apb_addr_t  paddr,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_data_t  pwdata,
    output apb_data_t  prdata,
    output logic       pready,
    output logic       pslverr,
    output logic       done,
    output logic       cke,
    output logic       src_rd_en,
    output addr_t      src_rd_addr,
    output logic [1:0] src_wr_en,
    output logic       src_wr_sel,
    output addr_t      src_wr_addr,
    output word_t      src_wr_data,
    output addr_t      res_rd_addr,
    input  word_t      prod_rd_data,
    input  word_t      sum_rd_data,
    input  word_t      src0_rd_data,
    input  word_t      src1_rd_data,
    output addr_t      dst_base,
    input  logic       run_done,
    lane_bus_if.src    issue
);

    seq_state_t state;
    logic       pause;
    logic       done_q;
    len_t       len;
    addr_t      src_base;
    len_t       cnt;
    addr_t      seq_addr;
    logic       wait_q;
    logic       busy;
    logic       access;
    logic       reg_hit;
    logic       src0_hit;
    logic       src1_hit;
    logic       prod_hit;
    logic       sum_hit;
    logic       err;
    logic       mem_rd;
    logic       wr_ok;
    logic       start_go;
    addr_t      win_addr;
    word_t      win_word;

    ////////////////////
    // address decode
    ////////////////////
    assign access   = psel & penable;
    assign busy     = (state != IDLE);
    assign win_addr = paddr[WIN_LSB-1:WORD_LSB];
    assign reg_hit  = (paddr == REG_CTRL) || (paddr == REG_STATUS) || (paddr == REG_LEN)
                   || (paddr == REG_SRC_BASE) || (paddr == REG_DST_BASE);
    assign src0_hit = (paddr[APB_ADDR_BITS-1:WIN_LSB] == SRC0_WIN[APB_ADDR_BITS-1:WIN_LSB]);
    assign src1_hit = (paddr[APB_ADDR_BITS-1:WIN_LSB] == SRC1_WIN[APB_ADDR_BITS-1:WIN_LSB]);
    assign prod_hit = (paddr[APB_ADDR_BITS-1:WIN_LSB] == PROD_WIN[APB_ADDR_BITS-1:WIN_LSB]);
    assign sum_hit  = (paddr[APB_ADDR_BITS-1:WIN_LSB] == SUM_WIN[APB_ADDR_BITS-1:WIN_LSB]);

    assign err = !(reg_hit || src0_hit || src1_hit || prod_hit || sum_hit)
              || (pwrite && (prod_hit || sum_hit))
              || (busy && (src0_hit || src1_hit));

    // errored accesses finish without a wait state.
    assign mem_rd   = !pwrite && !err && (src0_hit || src1_hit || prod_hit || sum_hit);
    assign pready   = access & (~mem_rd | wait_q);
    assign pslverr  = pready & err;
    assign wr_ok    = pready & pwrite & ~err;
    assign start_go = wr_ok && (paddr == REG_CTRL) && pwdata[0] && !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            wait_q <= 1'b0;
        end else begin
            wait_q <= access & mem_rd & ~wait_q;
        end
    end

    ////////////////////
    // memory ports
    ////////////////////
    assign cke         = ~pause;
    assign src_rd_en   = busy ? cke : 1'b1;
    assign src_rd_addr = busy ? seq_addr : win_addr;
    assign res_rd_addr = win_addr;
    assign src_wr_sel  = src1_hit;
    assign src_wr_addr = win_addr;
    assign src_wr_data = {pwdata, pwdata};
    assign src_wr_en   = (wr_ok && (src0_hit || src1_hit)) ? (paddr[2] ? 2'b10 : 2'b01) : 2'b00;

    always_comb begin
        win_word = src0_rd_data;
        if (src1_hit) begin
            win_word = src1_rd_data;
        end else if (prod_hit) begin
            win_word = prod_rd_data;
        end else if (sum_hit) begin
            win_word = sum_rd_data;
        end
    end

    always_comb begin
        prdata = '0;
        if (reg_hit) begin
            case (paddr)
                REG_CTRL:     prdata = {30'b0, pause, 1'b0};    // start reads zero.
                REG_STATUS:   prdata = {30'b0, done_q, busy};
                REG_LEN:      prdata = apb_data_t'(len);
                REG_SRC_BASE: prdata = apb_data_t'(src_base);
                default:      prdata = apb_data_t'(dst_base);
            endcase
        end else begin
            prdata = paddr[2] ? win_word[2*HALF_BITS-1:HALF_BITS] : win_word[HALF_BITS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pause    <= 1'b0;
            len      <= '0;
            src_base <= '0;
            dst_base <= '0;
        end else if (wr_ok) begin
            case (paddr)
                REG_CTRL:     pause    <= pwdata[1];
                REG_LEN:      len      <= pwdata[ADDR_BITS:0];
                REG_SRC_BASE: src_base <= pwdata[ADDR_BITS-1:0];
                REG_DST_BASE: dst_base <= pwdata[ADDR_BITS-1:0];
                default: ;
            endcase
        end
    end

    ////////////////////
    // sequencer
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            cnt         <= '0;
            seq_addr    <= '0;
            done_q      <= 1'b0;
            issue.valid <= 1'b0;
            issue.last  <= 1'b0;
        end else if (start_go) begin
            state    <= RUN;
            cnt      <= len;
            seq_addr <= src_base;
            done_q   <= 1'b0;
        end else if (cke) begin
            issue.valid <= (state == RUN) && (cnt != '0);   // ram data lands next cycle.
            issue.last  <= (state == RUN) && (cnt == len_t'(1));
            case (state)
                RUN: begin
                    if (cnt == '0) begin
                        state  <= IDLE;     // empty run.
                        done_q <= 1'b1;
                    end else begin
                        cnt      <= cnt - len_t'(1);
                        seq_addr <= seq_addr + addr_t'(1);
                        if (cnt == len_t'(1)) begin
                            state <= DRAIN;
                        end
                    end
                end
                DRAIN: begin
                    if (run_done) begin
                        state  <= IDLE;
                        done_q <= 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    assign done = done_q;

    // writeback finishes only while the sequencer drains.
    a_done_in_drain: assert property (@(posedge clk) disable iff (reset)
        run_done |-> (state == DRAIN));

endmodule

/* hdl/word_ram.sv */
`timescale 1ns/10ps

module word_ram import calc_pkg::*; (
    input  logic       clk,
    input  logic [1:0] wr_en,      // one per 32 bit half.
    input  addr_t      wr_addr,
    input  word_t      wr_data,
    input  logic       rd_en,
    input  addr_t      rd_addr,
    output word_t      rd_data
);

    word_t mem [2**ADDR_BITS];

    always_ff @(posedge clk) begin
        for (int h = 0; h < 2; h++) begin
            if (wr_en[h]) begin
                mem[wr_addr][h*HALF_BITS +: HALF_BITS] <= wr_data[h*HALF_BITS +: HALF_BITS];
            end
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];    // holds while disabled.
        end
    end

endmodule

/* common/lane_bus_if.sv */
`timescale 1ns/10ps

// word pair stream between the pipeline blocks.
interface lane_bus_if import calc_pkg::*; ();

    word_t data0;   // source 0 or product.
    word_t data1;   // source 1 or sum.
    logic  valid;
    logic  last;    // final word of a run.

    modport src (
        output data0,
        output data1,
        output valid,
        output last
    );

    modport dst (
        input data0,
        input data1,
        input valid,
        input last
    );

endinterface

/* common/calc_pkg.sv */
package calc_pkg;

    ////////////////////
    // widths
    ////////////////////
    localparam int DATA_BITS     = 8;
    localparam int LANES         = 8;
    localparam int ADDR_BITS     = 6;
    localparam int APB_ADDR_BITS = 12;
    localparam int HALF_BITS     = DATA_BITS * LANES / 2;

    // byte address fields of a memory window.
    localparam int WORD_LSB = 3;
    localparam int WIN_LSB  = WORD_LSB + ADDR_BITS;

    typedef logic signed [DATA_BITS-1:0]       lane_t;
    typedef logic [DATA_BITS*LANES-1:0]        word_t;
    typedef logic [ADDR_BITS-1:0]              addr_t;
    typedef logic [ADDR_BITS:0]                len_t;   // 0 to 64.
    typedef logic [APB_ADDR_BITS-1:0]          apb_addr_t;
    typedef logic [HALF_BITS-1:0]              apb_data_t;

    ////////////////////
    // register map
    ////////////////////
    localparam apb_addr_t REG_CTRL     = 12'h000;
    localparam apb_addr_t REG_STATUS   = 12'h004;
    localparam apb_addr_t REG_LEN      = 12'h008;
    localparam apb_addr_t REG_SRC_BASE = 12'h00C;
    localparam apb_addr_t REG_DST_BASE = 12'h010;

    // 512 byte windows.
    localparam apb_addr_t SRC0_WIN = 12'h400;
    localparam apb_addr_t SRC1_WIN = 12'h600;
    localparam apb_addr_t PROD_WIN = 12'h800;
    localparam apb_addr_t SUM_WIN  = 12'hA00;

    typedef enum logic [1:0] {IDLE, RUN, DRAIN} seq_state_t;

endpackage
